/* design/gate_pkg.sv */
package gate_pkg;

	// Local-bus address and data widths
	typedef logic [23:0] lb_addr_t;
	typedef logic [31:0] lb_data_t;

	// Read flag inside the control/address word
	localparam int ctl_read_bit = 28;

	// Bytes per nonce and per transaction
	localparam int frame_bytes = 8;

	// One reply byte plus end-of-transaction marker
	typedef struct packed {
		logic [7:0] data;
		logic       last;
	} tx_entry_t;

endpackage

/* design/lb_bus_if.sv */
interface lb_bus_if;
	import gate_pkg::*;

	// Address, write data and read flag hold from strobe to strobe
	lb_addr_t addr;
	lb_data_t wdata;
	logic     strobe;
	logic     rd;
	// Valid from the cycle after the strobe
	lb_data_t rdata;

	// Bus master side, in the gateway
	modport gateway (
		output addr,
		output wdata,
		output strobe,
		output rd,
		input  rdata
	);

	// Register bank side
	modport bank (
		input  addr,
		input  wdata,
		input  strobe,
		input  rd,
		output rdata
	);

endinterface

/* design/short_fifo.sv */
module short_fifo #(
	parameter type entry_t = logic [7:0],
	parameter int depth_log2 = 2
) (
	input  logic   clk,
	input  logic   rst_n,
	input  entry_t din,
	input  logic   we,
	input  logic   re,
	output entry_t dout,
	output logic   empty,
	output logic   full
);

	localparam int depth = 1 << depth_log2;

	// Pointers carry one extra wrap bit
	logic [depth_log2:0] wr_ptr;
	logic [depth_log2:0] rd_ptr;
	entry_t              mem [depth];
	logic                do_write;
	logic                do_read;

	// Full when only the wrap bits differ
	assign empty = (wr_ptr == rd_ptr);
	assign full  = (wr_ptr[depth_log2] != rd_ptr[depth_log2]) &&
		(wr_ptr[depth_log2-1:0] == rd_ptr[depth_log2-1:0]);

	// Writes into a full FIFO are dropped
	assign do_write = we && !full;
	assign do_read  = re && !empty;

	// Head entry is visible without a read
	assign dout = mem[rd_ptr[depth_log2-1:0]];

	always_ff @(posedge clk) begin
		if (do_write) begin
			mem[wr_ptr[depth_log2-1:0]] <= din;
		end
	end

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
		end else begin
			if (do_write) begin
				wr_ptr <= wr_ptr + 1'b1;
			end
			if (do_read) begin
				rd_ptr <= rd_ptr + 1'b1;
			end
		end
	end

endmodule

/* design/udp_lb_gate.sv */
module udp_lb_gate #(
	parameter int pipe_del = 3
) (
	input  logic       clk,
	input  logic       rst_n,
	// Byte stream from the host, no back-pressure
	input  logic [7:0] rx_din,
	input  logic       rx_stb,
	input  logic       rx_end,
	// Reply stream, pulled by the host
	output logic [7:0] tx_dout,
	output logic       tx_rdy,
	output logic       tx_end,
	input  logic       tx_stb,
	// Local bus master
	lb_bus_if.gateway  bus
);
	import gate_pkg::*;

	localparam int sr_bits  = 8 * frame_bytes;
	localparam int cnt_bits = $clog2(frame_bytes);
	localparam int pipe_len = pipe_del + frame_bytes;

	logic [cnt_bits-1:0] byte_cnt;
	logic                past_nonce;
	logic                nonce_done;
	logic                rx_active;
	logic                last_byte;
	logic                strobe_r;
	logic [sr_bits-1:0]  rx_sr;
	lb_data_t            ctl_word;
	lb_data_t            data_word;
	lb_addr_t            addr_q;
	lb_data_t            wdata_q;
	logic                rd_q;
	lb_data_t            ctl_head;
	logic [pipe_len-1:0] xfer_pipe;
	logic [frame_bytes-1:0] out_window;
	logic                sr_load;
	logic                drive_tx;
	logic                drive_done;
	logic [sr_bits-1:0]  tx_sr;
	logic                rx_loopback;
	tx_entry_t           reply_in;
	tx_entry_t           reply_head;
	logic                reply_we;
	logic                reply_empty;
	logic                fifo_re;
	logic                tx_done_rd;
	logic [5:0]          tx_pending;

	// Eighth byte of a frame arriving now
	assign last_byte = rx_stb && (byte_cnt == cnt_bits'(frame_bytes - 1));

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			byte_cnt   <= '0;
			past_nonce <= 1'b0;
			nonce_done <= 1'b0;
			rx_active  <= 1'b0;
			strobe_r   <= 1'b0;
		end else begin
			if (rx_stb) begin
				byte_cnt  <= byte_cnt + 1'b1;
				if (byte_cnt == cnt_bits'(frame_bytes - 1)) begin
					past_nonce <= 1'b1;
				end
				// Goes high with the first transaction byte
				nonce_done <= past_nonce;
				rx_active  <= 1'b1;
			end
			// End marker restarts framing for the next packet
			if (rx_end) begin
				byte_cnt   <= '0;
				past_nonce <= 1'b0;
				rx_active  <= 1'b0;
			end
			// Bus cycle one clock after a full transaction
			strobe_r <= last_byte && past_nonce;
		end
	end

	// Incoming bytes, big-endian
	always_ff @(posedge clk) begin
		if (rx_stb) begin
			rx_sr <= {rx_sr[sr_bits-9:0], rx_din};
		end
	end

	assign ctl_word  = rx_sr[sr_bits-1 -: 32];
	assign data_word = rx_sr[31:0];

	// Keep bus fields stable while the next frame shifts in
	always_ff @(posedge clk) begin
		if (strobe_r) begin
			rd_q    <= ctl_word[ctl_read_bit];
			addr_q  <= ctl_word[$bits(lb_addr_t)-1:0];
			wdata_q <= data_word;
		end
	end

	assign bus.strobe = strobe_r;
	assign bus.rd     = strobe_r ? ctl_word[ctl_read_bit] : rd_q;
	assign bus.addr   = strobe_r ? ctl_word[$bits(lb_addr_t)-1:0] : addr_q;
	assign bus.wdata  = strobe_r ? data_word : wdata_q;

	// Control words wait here for their read data
	short_fifo #(
		.entry_t    (lb_data_t),
		.depth_log2 (2)
	) i_cmd_fifo (
		.clk   (clk),
		.rst_n (rst_n),
		.din   (ctl_word),
		.we    (strobe_r),
		.re    (sr_load),
		.dout  (ctl_head),
		.empty (),
		.full  ()
	);

	// Strobe delay line; the low frame_bytes taps time the reply bytes
	assign out_window = xfer_pipe[frame_bytes-1:0];
	assign sr_load    = out_window[frame_bytes-1];

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			xfer_pipe  <= '0;
			drive_tx   <= 1'b0;
			drive_done <= 1'b0;
		end else begin
			xfer_pipe  <= {strobe_r, xfer_pipe[pipe_len-1:1]};
			drive_tx   <= |out_window;
			drive_done <= out_window[0];
		end
	end

	// Load control word plus sampled rdata, then shift out MSB first
	always_ff @(posedge clk) begin
		if (|out_window) begin
			tx_sr <= sr_load ? {ctl_head, bus.rdata} : {tx_sr[sr_bits-9:0], 8'h00};
		end
	end

	// Nonce goes straight back to the reply queue
	assign rx_loopback   = rx_stb && !past_nonce;
	assign reply_in.data = rx_loopback ? rx_din : tx_sr[sr_bits-1 -: 8];
	assign reply_in.last = drive_done;
	assign reply_we      = drive_tx || rx_loopback;

	short_fifo #(
		.entry_t    (tx_entry_t),
		.depth_log2 (5)
	) i_reply_fifo (
		.clk   (clk),
		.rst_n (rst_n),
		.din   (reply_in),
		.we    (reply_we),
		.re    (fifo_re),
		.dout  (reply_head),
		.empty (reply_empty),
		.full  ()
	);

	assign tx_rdy  = !reply_empty && nonce_done;
	assign fifo_re = tx_rdy && tx_stb;
	assign tx_dout = reply_head.data;

	// Transactions issued but not yet fully read out
	assign tx_done_rd = fifo_re && reply_head.last;

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			tx_pending <= '0;
		end else begin
			case ({strobe_r, tx_done_rd})
				2'b10:   tx_pending <= tx_pending + 1'b1;
				2'b01:   tx_pending <= tx_pending - 1'b1;
				default: tx_pending <= tx_pending;
			endcase
		end
	end

	// Final byte of the last outstanding transaction after rx_end
	assign tx_end = tx_rdy && reply_head.last && (tx_pending == 6'd1) && !rx_active;

endmodule

/* design/lb_reg_bank.sv */
module lb_reg_bank #(
	parameter int reg_count = 16
) (
	input  logic    clk,
	input  logic    rst_n,
	lb_bus_if.bank  bus
);
	import gate_pkg::*;

	localparam int idx_bits = $clog2(reg_count);

	lb_data_t            regs [reg_count];
	logic [idx_bits-1:0] idx;
	logic                wr_en;

	// Addresses wrap modulo the register count
	assign idx   = idx_bits'(bus.addr % reg_count);
	assign wr_en = bus.strobe && !bus.rd;

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			for (int i = 0; i < reg_count; i++) begin
				regs[i] <= '0;
			end
			bus.rdata <= '0;
		end else begin
			if (wr_en) begin
				regs[idx] <= bus.wdata;
			end
			// Read port shows the post-write value, one cycle late
			if (bus.strobe) begin
				bus.rdata <= bus.rd ? regs[idx] : bus.wdata;
			end
		end
	end

endmodule

/* design/lb_gate_top.sv */
module lb_gate_top #(
	parameter int pipe_del  = 3,
	parameter int reg_count = 16
) (
	input  logic       clk,
	input  logic       rst_n,
	// Host receive port
	input  logic [7:0] rx_din,
	input  logic       rx_stb,
	input  logic       rx_end,
	// Host transmit port
	output logic [7:0] tx_dout,
	output logic       tx_rdy,
	output logic       tx_end,
	input  logic       tx_stb
);

	// Internal local bus
	lb_bus_if bus ();

	// Packet parser and reply builder
	udp_lb_gate #(
		.pipe_del (pipe_del)
	) i_gate (
		.clk     (clk),
		.rst_n   (rst_n),
		.rx_din  (rx_din),
		.rx_stb  (rx_stb),
		.rx_end  (rx_end),
		.tx_dout (tx_dout),
		.tx_rdy  (tx_rdy),
		.tx_end  (tx_end),
		.tx_stb  (tx_stb),
		.bus     (bus.gateway)
	);

	// Registers behind the bus
	lb_reg_bank #(
		.reg_count (reg_count)
	) i_bank (
		.clk   (clk),
		.rst_n (rst_n),
		.bus   (bus.bank)
	);

endmodule

/* testbench/tb_lb_gate.sv */
module tb_lb_gate;

	localparam int reg_count  = 16;
	localparam int clk_period = 8;
	// Six tests of at most 32 bytes in and 32 out with idle cycles plus margin
	localparam int test_cycles     = 3000;
	localparam int watchdog_cycles = 6 * test_cycles + 2000;
	// Longest wait for one reply to finish
	localparam int collect_limit = 600;

	logic       clk;
	logic       rst_n;
	logic [7:0] rx_din;
	logic       rx_stb;
	logic       rx_end;
	logic [7:0] tx_dout;
	logic       tx_rdy;
	logic       tx_end;
	logic       tx_stb;

	logic [31:0] lfsr;
	logic [31:0] model_regs [reg_count];
	// Transactions of the packet being sent with the control word in the upper half
	logic [63:0] txn_q [$];
	logic [7:0]  exp_q [$];
	logic [7:0]  got_q [$];
	logic        end_q [$];
	int          errors;
	int          tests_run;
	int          tests_failed;

	lb_gate_top i_lb_gate_top (
		.clk     (clk),
		.rst_n   (rst_n),
		.rx_din  (rx_din),
		.rx_stb  (rx_stb),
		.rx_end  (rx_end),
		.tx_dout (tx_dout),
		.tx_rdy  (tx_rdy),
		.tx_end  (tx_end),
		.tx_stb  (tx_stb)
	);

	initial begin
		clk = 1'b0;
		forever #(clk_period / 2) clk = ~clk;
	end

	// Ends a run that got stuck
	initial begin
		repeat (watchdog_cycles) @(posedge clk);
		$display("Watchdog expired after %0d cycles", watchdog_cycles);
		$display("Finished with errors");
		$finish;
	end

	// Fibonacci LFSR with taps 32 22 2 1
	function automatic logic [31:0] lfsr_step(input logic [31:0] s);
		return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
	endfunction

	function automatic logic [63:0] wr_txn(input int addr, input logic [31:0] data);
		return {8'h00, addr[23:0], data};
	endfunction

	// Bit 28 set marks a read and the data field is don't care
	function automatic logic [63:0] rd_txn(input int addr);
		return {3'b000, 1'b1, 4'h0, addr[23:0], 32'hdead_beef};
	endfunction

	// Nonce echo, then control word and post-write register value per transaction
	task automatic predict_reply(input logic [63:0] nonce);
		logic [31:0] ctl;
		logic [31:0] val;
		int          idx;
		exp_q.delete();
		for (int i = 7; i >= 0; i--) begin
			exp_q.push_back(nonce[i*8 +: 8]);
		end
		foreach (txn_q[t]) begin
			ctl = txn_q[t][63:32];
			idx = int'(ctl[23:0]) % reg_count;
			if (!ctl[28]) begin
				model_regs[idx] = txn_q[t][31:0];
			end
			val = model_regs[idx];
			for (int i = 3; i >= 0; i--) begin
				exp_q.push_back(ctl[i*8 +: 8]);
			end
			for (int i = 3; i >= 0; i--) begin
				exp_q.push_back(val[i*8 +: 8]);
			end
		end
	endtask

	task automatic send_byte(input logic [7:0] b);
		@(posedge clk);
		rx_din <= b;
		rx_stb <= 1'b1;
	endtask

	// One big-endian byte per cycle and then rx_end on its own
	task automatic send_packet(input logic [63:0] nonce);
		for (int i = 7; i >= 0; i--) begin
			send_byte(nonce[i*8 +: 8]);
		end
		foreach (txn_q[t]) begin
			for (int i = 7; i >= 0; i--) begin
				send_byte(txn_q[t][i*8 +: 8]);
			end
		end
		@(posedge clk);
		rx_stb <= 1'b0;
		rx_end <= 1'b1;
		@(posedge clk);
		rx_end <= 1'b0;
	endtask

	// Pull bytes up to the one flagged by tx_end with optional idle cycles
	task automatic collect_reply(input bit stall);
		int cycles;
		bit done;
		got_q.delete();
		end_q.delete();
		cycles = 0;
		done   = 1'b0;
		@(posedge clk);
		tx_stb <= 1'b1;
		while (!done && cycles < collect_limit) begin
			// Transfer happens on the next rising edge
			@(negedge clk);
			if (tx_rdy && tx_stb) begin
				got_q.push_back(tx_dout);
				end_q.push_back(tx_end);
				done = tx_end;
			end
			@(posedge clk);
			if (stall) begin
				lfsr = lfsr_step(lfsr);
				tx_stb <= !done && !lfsr[0];
			end else begin
				tx_stb <= !done;
			end
			cycles++;
		end
		if (!done) begin
			$display("Reply did not end with tx_end within %0d cycles", collect_limit);
			errors++;
		end
	endtask

	task automatic check_reply();
		if (got_q.size() != exp_q.size()) begin
			$display("FAIL %0t tx_dout byte count: got %0d expected %0d", $time,
				got_q.size(), exp_q.size());
			errors++;
		end
		for (int i = 0; i < got_q.size() && i < exp_q.size(); i++) begin
			if (got_q[i] !== exp_q[i]) begin
				$display("FAIL %0t tx_dout[%0d]: got %h expected %h", $time, i, got_q[i],
					exp_q[i]);
				errors++;
			end
			// tx_end only on the final byte
			if (end_q[i] !== (i == exp_q.size() - 1)) begin
				$display("FAIL %0t tx_end[%0d]: got %b expected %b", $time, i, end_q[i],
					i == exp_q.size() - 1);
				errors++;
			end
		end
	endtask

	task automatic run_packet(input logic [63:0] nonce, input bit stall);
		predict_reply(nonce);
		send_packet(nonce);
		collect_reply(stall);
		check_reply();
	endtask

	task automatic report_test(input string name, input int errors_before);
		tests_run++;
		if (errors == errors_before) begin
			$display("Test %s: ok", name);
		end else begin
			tests_failed++;
			$display("Test %s: %0d errors", name, errors - errors_before);
		end
	endtask

	task automatic test_reset_state();
		int e0;
		e0 = errors;
		repeat (20) begin
			@(negedge clk);
			if (tx_rdy !== 1'b0) begin
				$display("FAIL %0t tx_rdy: got %b expected 0", $time, tx_rdy);
				errors++;
			end
			if (tx_end !== 1'b0) begin
				$display("FAIL %0t tx_end: got %b expected 0", $time, tx_end);
				errors++;
			end
		end
		report_test("reset_state", e0);
	endtask

	task automatic test_write_read();
		int e0;
		e0 = errors;
		txn_q.delete();
		txn_q.push_back(wr_txn(5, 32'hcafe_0123));
		run_packet(64'h0102_0304_0506_0708, 1'b0);
		txn_q.delete();
		txn_q.push_back(rd_txn(5));
		run_packet(64'h1122_3344_5566_7788, 1'b0);
		report_test("write_read", e0);
	endtask

	task automatic test_mixed();
		int e0;
		e0 = errors;
		txn_q.delete();
		txn_q.push_back(wr_txn(3, 32'h1357_9bdf));
		txn_q.push_back(rd_txn(5));
		txn_q.push_back(wr_txn(7, 32'h2468_ace0));
		run_packet(64'ha5a5_5a5a_0f0f_f0f0, 1'b0);
		report_test("mixed", e0);
	endtask

	task automatic test_tx_stalls();
		int e0;
		e0 = errors;
		txn_q.delete();
		txn_q.push_back(wr_txn(9, 32'h8765_4321));
		txn_q.push_back(rd_txn(3));
		txn_q.push_back(rd_txn(9));
		run_packet(64'hfeed_face_0bad_f00d, 1'b1);
		report_test("tx_stalls", e0);
	endtask

	// Address reg_count + 2 lands on register 2
	task automatic test_addr_wrap();
		int e0;
		e0 = errors;
		txn_q.delete();
		txn_q.push_back(wr_txn(reg_count + 2, 32'h0bad_cafe));
		txn_q.push_back(rd_txn(2));
		run_packet(64'h3c3c_c3c3_9696_6969, 1'b0);
		report_test("addr_wrap", e0);
	endtask

	task automatic test_back_to_back();
		int e0;
		e0 = errors;
		txn_q.delete();
		txn_q.push_back(wr_txn(11, 32'h5555_aaaa));
		run_packet(64'h0000_0001_0000_0002, 1'b0);
		txn_q.delete();
		txn_q.push_back(rd_txn(11));
		txn_q.push_back(rd_txn(7));
		run_packet(64'h8000_0000_4000_0000, 1'b0);
		report_test("back_to_back", e0);
	endtask

	initial begin
		rst_n        = 1'b0;
		rx_din       = 8'h00;
		rx_stb       = 1'b0;
		rx_end       = 1'b0;
		tx_stb       = 1'b0;
		lfsr         = 32'h596;
		errors       = 0;
		tests_run    = 0;
		tests_failed = 0;
		// Registers come out of reset as zero
		for (int i = 0; i < reg_count; i++) begin
			model_regs[i] = 32'h0;
		end
		repeat (4) @(posedge clk);
		rst_n <= 1'b1;

		test_reset_state();
		test_write_read();
		test_mixed();
		test_tx_stalls();
		test_addr_wrap();
		test_back_to_back();

		$display("Tests run %0d, failed %0d, errors %0d", tests_run, tests_failed, errors);
		if (errors == 0) begin
			$display("Finished with no errors");
		end else begin
			$display("Finished with errors");
		end
		$finish;
	end

endmodule

/* verilog.f */
design/gate_pkg.sv
design/lb_bus_if.sv
design/short_fifo.sv
design/udp_lb_gate.sv
design/lb_reg_bank.sv
design/lb_gate_top.sv
testbench/tb_lb_gate.sv

/* Makefile */
# Verilator build and run of the local-bus gateway testbench

OBJ_DIR := obj_dir

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  help   list these targets"
	@echo "  test   build and run the testbench, fails unless the run passes"
	@echo "  clean  remove the build output"

test:
	verilator --binary --timing -Wno-fatal -f verilog.f \
		--top-module tb_lb_gate --Mdir $(OBJ_DIR) -o sim_lb_gate
	@out=$$(./$(OBJ_DIR)/sim_lb_gate); \
	echo "$$out"; \
	echo "$$out" | grep -qx "Finished with no errors"

clean:
	rm -rf $(OBJ_DIR)
